// File: bench/tb_nabp_filtered_line_buffer.sv
`timescale 1ns/1ps
`include "nabp_macros.svh"

module tb_nabp_filtered_line_buffer;

    localparam int LINE_SIZE = `NABP_LINE_SIZE;
    localparam int HALF = `NABP_FILTER_ORDER / 2;
    localparam int NUM_LINES = 3;
    localparam int NUM_ROWS = 10;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (LINE_SIZE + 20) + 8;
    localparam int READY_LIMIT = LINE_SIZE + `NABP_FILTER_ORDER + 10;

    typedef enum logic [2:0]
    {
        OP_FILL,
        OP_KICK_BUSY,
        OP_SWAP,
        OP_SWAP_IDLE
    } op_t;

    // operation, host line, line the processing side should see (-1 for none)
    typedef struct packed
    {
        op_t op;
        int  line_idx;
        int  exp_line;
    } row_t;

    logic                clk;
    logic                reset_n;
    logic                line_kick;
    logic                swap;
    logic                line_busy;
    logic                line_ready;
    nabp_pkg::sample_t   sample_val;
    nabp_pkg::s_idx_t    sample_s;
    nabp_pkg::s_idx_t    pr0_s;
    nabp_pkg::s_idx_t    pr1_s;
    nabp_pkg::filtered_t pr0_val;
    nabp_pkg::filtered_t pr1_val;

    nabp_pkg::sample_t line_mem [0:NUM_LINES-1][0:LINE_SIZE-1];
    row_t              table_rows [0:NUM_ROWS-1];
    int                cur_line;
    int                seed;
    int                error_count;
    logic              exp_ready;

    // host answers the requested index in the same cycle
    assign sample_val = line_mem[cur_line][sample_s];

    nabp_filtered_line_buffer u_nabp_filtered_line_buffer
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .line_kick  (line_kick),
        .sample_val (sample_val),
        .sample_s   (sample_s),
        .line_busy  (line_busy),
        .line_ready (line_ready),
        .swap       (swap),
        .pr0_s      (pr0_s),
        .pr1_s      (pr1_s),
        .pr0_val    (pr0_val),
        .pr1_val    (pr1_val)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

    // kernel applied with zero history before the line and a held last sample
    function automatic nabp_pkg::filtered_t filter_ref(input int line_idx, input int addr);
        int acc;
        int k;
        int x;
        acc = 0;
        for (int j = -HALF; j <= HALF; j++)
        begin
            k = addr + j;
            if (k > LINE_SIZE - 1)
            begin
                k = LINE_SIZE - 1;
            end
            x = (k < 0) ? 0 : int'(line_mem[line_idx][k]);
            acc = acc + nabp_pkg::FILTER_COEF[j + HALF] * x;
        end
        if (acc > (1 << (`NABP_FILTERED_W - 1)) - 1)
        begin
            acc = (1 << (`NABP_FILTERED_W - 1)) - 1;
        end
        else if (acc < -(1 << (`NABP_FILTERED_W - 1)))
        begin
            acc = -(1 << (`NABP_FILTERED_W - 1));
        end
        return nabp_pkg::filtered_t'(acc);
    endfunction

    task automatic check_filtered(input string name, input nabp_pkg::filtered_t expected,
                                  input nabp_pkg::filtered_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1, "filtered value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("Test failed");
            $fatal(1, "status flag mismatch");
        end
    endtask

    task automatic check_index(input string name, input nabp_pkg::s_idx_t expected,
                               input nabp_pkg::s_idx_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1, "host index mismatch");
        end
    endtask

    // port 0 walks up, port 1 walks down, data checked one cycle later
    task automatic read_all(input int line_idx, input string name);
        int prev0;
        int prev1;
        prev0 = 0;
        prev1 = 0;
        for (int i = 0; i <= LINE_SIZE; i++)
        begin
            if (i > 0)
            begin
                check_filtered($sformatf("%s pr0[%0d]", name, prev0),
                               filter_ref(line_idx, prev0), pr0_val);
                check_filtered($sformatf("%s pr1[%0d]", name, prev1),
                               filter_ref(line_idx, prev1), pr1_val);
            end
            if (i < LINE_SIZE)
            begin
                prev0 = i;
                prev1 = LINE_SIZE - 1 - i;
                pr0_s = nabp_pkg::s_idx_t'(prev0);
                pr1_s = nabp_pkg::s_idx_t'(prev1);
            end
            @(negedge clk);
        end
    endtask

    // host index counts up from 0 through delay and fill and holds at the line end
    task automatic follow_host_index(input string name);
        int expected;
        // the accepted and the dropped kick already took the first two cycles
        for (int age = 2; age <= HALF + LINE_SIZE; age++)
        begin
            expected = age - 1;
            if (expected > LINE_SIZE - 1)
            begin
                expected = LINE_SIZE - 1;
            end
            check_index($sformatf("%s sample_s %0d cycles after kick", name, age),
                        nabp_pkg::s_idx_t'(expected), sample_s);
            @(negedge clk);
        end
    endtask

    task automatic pulse_kick();
        line_kick = 1'b1;
        @(negedge clk);
        line_kick = 1'b0;
    endtask

    task automatic pulse_swap();
        swap = 1'b1;
        @(negedge clk);
        swap = 1'b0;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (line_ready !== 1'b1 && cycles < READY_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (line_ready !== 1'b1)
        begin
            $display("line_ready did not rise within %0d cycles after the kick", READY_LIMIT);
            $display("Test failed");
            $fatal(1, "fill did not complete");
        end
    endtask

    task automatic run_row(input row_t row, input int r);
        string name;
        name = $sformatf("row %0d %s", r, row.op.name());
        check_flag({name, " line_ready at start"}, exp_ready, line_ready);
        check_flag({name, " line_busy at start"}, exp_ready, line_busy);
        case (row.op)
            OP_FILL:
            begin
                cur_line = row.line_idx;
                pulse_kick();
                check_flag({name, " line_busy in fill"}, 1'b1, line_busy);
                check_flag({name, " line_ready in fill"}, 1'b0, line_ready);
                // lands in the delay phase and must be dropped
                pulse_kick();
                fork
                    follow_host_index(name);
                    begin
                        if (row.exp_line >= 0)
                        begin
                            read_all(row.exp_line, name);
                        end
                    end
                join
                wait_ready();
                check_flag({name, " line_busy when ready"}, 1'b1, line_busy);
                exp_ready = 1'b1;
            end
            OP_KICK_BUSY:
            begin
                cur_line = row.line_idx;
                pulse_kick();
                repeat (4) @(negedge clk);
                check_flag({name, " line_ready held"}, 1'b1, line_ready);
                check_flag({name, " line_busy held"}, 1'b1, line_busy);
                if (row.exp_line >= 0)
                begin
                    read_all(row.exp_line, name);
                end
            end
            default:
            begin
                pulse_swap();
                @(negedge clk);
                exp_ready = 1'b0;
                check_flag({name, " line_ready after swap"}, 1'b0, line_ready);
                check_flag({name, " line_busy after swap"}, 1'b0, line_busy);
                read_all(row.exp_line, name);
            end
        endcase
    endtask

    task automatic load_table();
        table_rows[0] = '{OP_FILL, 0, -1};
        table_rows[1] = '{OP_KICK_BUSY, 1, -1};
        table_rows[2] = '{OP_SWAP, 0, 0};
        table_rows[3] = '{OP_SWAP_IDLE, 0, 0};
        table_rows[4] = '{OP_FILL, 1, 0};
        table_rows[5] = '{OP_SWAP, 1, 1};
        table_rows[6] = '{OP_FILL, 2, 1};
        table_rows[7] = '{OP_KICK_BUSY, 0, 1};
        table_rows[8] = '{OP_SWAP, 2, 2};
        table_rows[9] = '{OP_SWAP_IDLE, 2, 2};
    endtask

    initial
    begin
        seed        = 11300;
        error_count = 0;
        exp_ready   = 1'b0;
        cur_line    = 0;
        reset_n     = 1'b0;
        line_kick   = 1'b0;
        swap        = 1'b0;
        pr0_s       = '0;
        pr1_s       = '0;
        for (int l = 0; l < NUM_LINES; l++)
        begin
            for (int i = 0; i < LINE_SIZE; i++)
            begin
                line_mem[l][i] = nabp_pkg::sample_t'($random(seed));
            end
        end
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_flag("after reset line_busy", 1'b0, line_busy);
        check_flag("after reset line_ready", 1'b0, line_ready);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(table_rows[r], r);
        end
        if (error_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: hdl/nabp_dual_port_ram.sv
`timescale 1ns/1ps
`include "nabp_macros.svh"

module nabp_dual_port_ram
(
    input  logic                clk,
    input  logic                we_0,
    input  nabp_pkg::s_idx_t    addr_0,
    input  nabp_pkg::s_idx_t    addr_1,
    input  nabp_pkg::filtered_t data_in_0,
    output nabp_pkg::filtered_t data_out_0,
    output nabp_pkg::filtered_t data_out_1
);

    // one filtered projection line
    nabp_pkg::filtered_t mem [0:`NABP_LINE_SIZE-1];

    // port 0: write and read, read returns the old word
    always_ff @(posedge clk)
    begin
        if (we_0)
        begin
            mem[addr_0] <= data_in_0;
        end
        data_out_0 <= mem[addr_0];
    end

    // port 1 is read only
    always_ff @(posedge clk)
    begin
        data_out_1 <= mem[addr_1];
    end

endmodule

// File: hdl/nabp_filtered_line_buffer.sv
`timescale 1ns/1ps

module nabp_filtered_line_buffer
(
    input  logic                clk,
    input  logic                reset_n,
    // host side
    input  logic                line_kick,
    input  nabp_pkg::sample_t   sample_val,
    output nabp_pkg::s_idx_t    sample_s,
    // status
    output logic                line_busy,
    output logic                line_ready,
    // processing side
    input  logic                swap,
    input  nabp_pkg::s_idx_t    pr0_s,
    input  nabp_pkg::s_idx_t    pr1_s,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    nabp_fill_if host_fill_if();
    nabp_fill_if fill0_if();
    nabp_fill_if fill1_if();

    nabp_read_if user_rd_if();
    nabp_read_if rd0_if();
    nabp_read_if rd1_if();

    assign host_fill_if.kick = line_kick;
    assign sample_s          = host_fill_if.s_val;

    assign user_rd_if.pr0_s = pr0_s;
    assign user_rd_if.pr1_s = pr1_s;
    assign pr0_val          = user_rd_if.pr0_val;
    assign pr1_val          = user_rd_if.pr1_val;

    // history clears on whichever bank accepts the kick
    nabp_fir_filter u_nabp_fir_filter
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .clear        (fill0_if.kick | fill1_if.kick),
        .sample_val   (sample_val),
        .filtered_val (host_fill_if.val)
    );

    nabp_swap_control u_nabp_swap_control
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .swap       (swap),
        .line_busy  (line_busy),
        .line_ready (line_ready),
        .host_fill  (host_fill_if.bank),
        .fill0      (fill0_if.ctrl),
        .fill1      (fill1_if.ctrl),
        .user_rd    (user_rd_if.bank),
        .rd0        (rd0_if.user),
        .rd1        (rd1_if.user)
    );

    nabp_filtered_ram_swappable u_bank0
    (
        .clk     (clk),
        .reset_n (reset_n),
        .fill    (fill0_if.bank),
        .rd      (rd0_if.bank)
    );

    nabp_filtered_ram_swappable u_bank1
    (
        .clk     (clk),
        .reset_n (reset_n),
        .fill    (fill1_if.bank),
        .rd      (rd1_if.bank)
    );

endmodule

// File: hdl/nabp_filtered_ram_swappable.sv
`timescale 1ns/1ps
`include "nabp_macros.svh"

module nabp_filtered_ram_swappable
(
    input logic       clk,
    input logic       reset_n,
    nabp_fill_if.bank fill,
    nabp_read_if.bank rd
);

    localparam nabp_pkg::s_idx_t LAST_S = nabp_pkg::s_idx_t'(`NABP_LINE_SIZE - 1);
    localparam nabp_pkg::s_idx_t DELAY_LAST = nabp_pkg::s_idx_t'(`NABP_FILTER_ORDER / 2 - 1);

    nabp_pkg::fill_state_t state;
    nabp_pkg::fill_state_t next_state;
    nabp_pkg::s_idx_t      write_itr;
    nabp_pkg::s_idx_t      read_itr;
    nabp_pkg::s_idx_t      addr_0;
    logic                  delay_done;
    logic                  last_write;
    logic                  write_enable;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_pkg::ready_s;
        end
        else
        begin
            state <= next_state;
        end
    end

    // read index runs ahead of the write index by the filter delay
    always_ff @(posedge clk)
    begin
        if (!reset_n || state == nabp_pkg::ready_s)
        begin
            read_itr  <= '0;
            write_itr <= '0;
        end
        else if (state == nabp_pkg::delay_s)
        begin
            read_itr <= read_itr + 1'b1;
        end
        else if (!last_write)
        begin
            write_itr <= write_itr + 1'b1;
            // hold on the last sample to replicate the line end
            if (read_itr != LAST_S)
            begin
                read_itr <= read_itr + 1'b1;
            end
        end
    end

    assign delay_done   = (read_itr == DELAY_LAST);
    assign last_write   = (write_itr == LAST_S);
    assign write_enable = (state == nabp_pkg::fill_s);

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready_s:
                if (fill.kick)
                begin
                    next_state = nabp_pkg::delay_s;
                end
            nabp_pkg::delay_s:
                if (delay_done)
                begin
                    next_state = nabp_pkg::fill_s;
                end
            nabp_pkg::fill_s:
                if (last_write)
                begin
                    next_state = nabp_pkg::ready_s;
                end
            default:
                next_state = nabp_pkg::ready_s;
        endcase
    end

    assign fill.done  = write_enable && last_write;
    assign fill.s_val = read_itr;

    // reader owns port 0 only while idle
    assign addr_0 = (state == nabp_pkg::ready_s) ? rd.pr0_s : write_itr;

    nabp_dual_port_ram u_nabp_dual_port_ram
    (
        .clk        (clk),
        .we_0       (write_enable),
        .addr_0     (addr_0),
        .addr_1     (rd.pr1_s),
        .data_in_0  (fill.val),
        .data_out_0 (rd.pr0_val),
        .data_out_1 (rd.pr1_val)
    );

    assert property (@(posedge clk) disable iff (!reset_n)
        write_enable |-> (write_itr <= LAST_S));

    // done closes a fill of exactly one line that followed the delay
    assert property (@(posedge clk) disable iff (!reset_n)
        fill.done |-> (state == nabp_pkg::fill_s) &&
                      ($past(state, `NABP_LINE_SIZE) == nabp_pkg::delay_s));

endmodule

// File: hdl/nabp_fir_filter.sv
`timescale 1ns/1ps
`include "nabp_macros.svh"

module nabp_fir_filter
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear,
    input  nabp_pkg::sample_t   sample_val,
    output nabp_pkg::filtered_t filtered_val
);

    localparam int ACC_W = `NABP_SAMPLE_W + 8;
    localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (`NABP_FILTERED_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - 1;

    // tap 0 is the live sample, taps 1..order are registered
    nabp_pkg::sample_t [`NABP_FILTER_ORDER:1] history;
    logic signed [ACC_W-1:0] acc;

    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
        begin
            history <= '0;
        end
        else
        begin
            history[1] <= sample_val;
            for (int i = 2; i <= `NABP_FILTER_ORDER; i++)
            begin
                history[i] <= history[i-1];
            end
        end
    end

    // multiply-accumulate over the whole window
    always_comb
    begin
        acc = ACC_W'(sample_val * nabp_pkg::FILTER_COEF[0]);
        for (int i = 1; i <= `NABP_FILTER_ORDER; i++)
        begin
            acc = acc + ACC_W'(history[i] * nabp_pkg::FILTER_COEF[i]);
        end
    end

    // saturate into the stored word
    always_comb
    begin
        if (acc > SAT_MAX)
        begin
            filtered_val = nabp_pkg::filtered_t'(SAT_MAX);
        end
        else if (acc < SAT_MIN)
        begin
            filtered_val = nabp_pkg::filtered_t'(SAT_MIN);
        end
        else
        begin
            filtered_val = nabp_pkg::filtered_t'(acc);
        end
    end

    // cleared history leaves only the live tap in the output
    assert property (@(posedge clk) disable iff (!reset_n)
        clear |=> (history == '0) &&
                  (filtered_val == nabp_pkg::filtered_t'(sample_val * nabp_pkg::FILTER_COEF[0])));

endmodule

// File: hdl/nabp_ifs.sv
`timescale 1ns/1ps

// fill traffic between the swap control and one bank
interface nabp_fill_if;

    logic                kick;
    nabp_pkg::filtered_t val;
    nabp_pkg::s_idx_t    s_val;
    logic                done;

    modport ctrl
    (
        output kick,
        output val,
        input  s_val,
        input  done
    );

    modport bank
    (
        input  kick,
        input  val,
        output s_val,
        output done
    );

endinterface

// two read ports, data one cycle after the address
interface nabp_read_if;

    nabp_pkg::s_idx_t    pr0_s;
    nabp_pkg::s_idx_t    pr1_s;
    nabp_pkg::filtered_t pr0_val;
    nabp_pkg::filtered_t pr1_val;

    modport user
    (
        output pr0_s,
        output pr1_s,
        input  pr0_val,
        input  pr1_val
    );

    modport bank
    (
        input  pr0_s,
        input  pr1_s,
        output pr0_val,
        output pr1_val
    );

endinterface

// File: hdl/nabp_macros.svh
`ifndef NABP_MACROS_SVH
`define NABP_MACROS_SVH

// raw projection sample from the host
`define NABP_SAMPLE_W 12

// filter output word stored in the line RAM
`define NABP_FILTERED_W 16

// wide enough to index one full line
`define NABP_S_W 7

// samples per projection line
`define NABP_LINE_SIZE 100

// taps = order + 1, order must be even
`define NABP_FILTER_ORDER 4

`endif

// File: hdl/nabp_pkg.sv
`include "nabp_macros.svh"

package nabp_pkg;

    typedef logic signed [`NABP_SAMPLE_W-1:0] sample_t;

    typedef logic signed [`NABP_FILTERED_W-1:0] filtered_t;

    typedef logic [`NABP_S_W-1:0] s_idx_t;

    // fill controller of one swappable bank
    typedef enum logic [1:0]
    {
        ready_s,
        delay_s,
        fill_s
    } fill_state_t;

    // symmetric ramp-like kernel, centre tap at index order/2
    localparam int FILTER_COEF [0:`NABP_FILTER_ORDER] = '{-1, -2, 6, -2, -1};

endpackage

// File: hdl/nabp_swap_control.sv
`timescale 1ns/1ps

module nabp_swap_control
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      swap,
    output logic      line_busy,
    output logic      line_ready,
    nabp_fill_if.bank host_fill,
    nabp_fill_if.ctrl fill0,
    nabp_fill_if.ctrl fill1,
    nabp_read_if.bank user_rd,
    nabp_read_if.user rd0,
    nabp_read_if.user rd1
);

    // processing side owns bank bank_sel, the other one fills
    logic bank_sel;
    logic rd_sel;
    logic fill_active;
    logic kick_ok;

    assign line_busy = fill_active | line_ready;
    assign kick_ok   = host_fill.kick & ~line_busy;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            bank_sel    <= 1'b0;
            rd_sel      <= 1'b0;
            fill_active <= 1'b0;
            line_ready  <= 1'b0;
        end
        else
        begin
            // data comes back a cycle after the address
            rd_sel <= bank_sel;
            if (kick_ok)
            begin
                fill_active <= 1'b1;
            end
            else if (host_fill.done)
            begin
                fill_active <= 1'b0;
            end
            if (host_fill.done)
            begin
                line_ready <= 1'b1;
            end
            else if (swap && line_ready)
            begin
                line_ready <= 1'b0;
                bank_sel   <= ~bank_sel;
            end
        end
    end

    // fill side goes to the bank not owned by processing
    assign fill0.kick = kick_ok & bank_sel;
    assign fill1.kick = kick_ok & ~bank_sel;
    assign fill0.val  = host_fill.val;
    assign fill1.val  = host_fill.val;

    assign host_fill.s_val = bank_sel ? fill0.s_val : fill1.s_val;
    assign host_fill.done  = bank_sel ? fill0.done : fill1.done;

    // read side
    assign rd0.pr0_s = bank_sel ? '0 : user_rd.pr0_s;
    assign rd0.pr1_s = bank_sel ? '0 : user_rd.pr1_s;
    assign rd1.pr0_s = bank_sel ? user_rd.pr0_s : '0;
    assign rd1.pr1_s = bank_sel ? user_rd.pr1_s : '0;

    assign user_rd.pr0_val = rd_sel ? rd1.pr0_val : rd0.pr0_val;
    assign user_rd.pr1_val = rd_sel ? rd1.pr1_val : rd0.pr1_val;

    // the bank being read never completes a fill
    assert property (@(posedge clk) disable iff (!reset_n)
        line_busy |-> !(bank_sel ? fill1.done : fill0.done));

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the line buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_nabp_filtered_line_buffer \
    -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?

if grep -q "Test failed" sim.log; then
    echo "FAIL: see sim.log"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

echo "PASS"
exit 0

// File: vlog.f
+incdir+hdl
hdl/nabp_pkg.sv
hdl/nabp_ifs.sv
hdl/nabp_dual_port_ram.sv
hdl/nabp_fir_filter.sv
hdl/nabp_filtered_ram_swappable.sv
hdl/nabp_swap_control.sv
hdl/nabp_filtered_line_buffer.sv
bench/tb_nabp_filtered_line_buffer.sv
